/* common/flow_if.sv */
// flow command bundle
// carries the five per-stage commands from flow_ctrl to the pipeline registers

`timescale 1ns/1ns

interface flow_if;

    flow_pkg::flow_t pc;   // fetch address register
    flow_pkg::flow_t de;
    flow_pkg::flow_t ex;
    flow_pkg::flow_t as;
    flow_pkg::flow_t wb;

    // controller side drives everything
    modport ctrl (output pc, de, ex, as, wb);

    // pc register only cares about its own command
    modport pc_side (input pc);

    // stage tag chain
    modport pipe (input de, ex, as, wb);

endinterface

/* common/flow_pkg.sv */
// flow control package
// shared word type, per-stage flow commands and branch/jump encodings

package flow_pkg;

    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;   // address or data word

    // --------------------
    // per-stage flow command
    typedef enum logic [1:0] {
        FLOW_WORK    = 2'd0,   // load from predecessor
        FLOW_STOP    = 2'd1,   // hold current contents
        FLOW_REFRESH = 2'd2    // turn into a bubble
    } flow_t;

    // --------------------
    // branch and jump types from decode
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } branch_t;

    typedef enum logic [1:0] {
        JMP_NONE = 2'd0,
        JMP_JAL,
        JMP_JALR,
        JMP_FENCE
    } jump_t;

    localparam word_t RESET_PC = 32'h0000_0000;   // first fetch address
    localparam word_t PC_STEP  = 32'd4;           // one instruction

endpackage

/* flist.f */
common/flow_pkg.sv
common/flow_if.sv
flow_ctrl/branch_cmp.sv
flow_ctrl/flow_ctrl.sv
src/pc_reg.sv
src/stage_chain.sv
src/pipe_ctrl_top.sv
sim/tb_pipe_ctrl.sv

/* flow_ctrl/branch_cmp.sv */
// branch comparator
// compares rs1 against rs2, unsigned for bltu/bgeu and signed otherwise

`timescale 1ns/1ns

module branch_cmp (
    input  flow_pkg::branch_t branch_i,
    input  flow_pkg::word_t   rs1_i,
    input  flow_pkg::word_t   rs2_i,
    output logic              zero_o,      // operands equal
    output logic              less_o,
    output logic              more_eq_o
);

    logic use_unsigned;
    logic lt_signed;
    logic lt_unsigned;

    assign use_unsigned = (branch_i == flow_pkg::BR_BLTU) ||
                          (branch_i == flow_pkg::BR_BGEU);

    // --------------------
    // both compares in parallel, pick one
    assign lt_signed   = $signed(rs1_i) < $signed(rs2_i);
    assign lt_unsigned = rs1_i < rs2_i;

    assign zero_o    = (rs1_i == rs2_i);
    assign less_o    = use_unsigned ? lt_unsigned : lt_signed;
    assign more_eq_o = ~less_o;   // complement of less

endmodule

/* flow_ctrl/flow_ctrl.sv */
// pipeline flow controller
// picks work/stop/refresh for each stage by priority and selects the next pc

`timescale 1ns/1ns

module flow_ctrl (
    input  logic               int_assert_i,
    input  flow_pkg::word_t    int_addr_i,
    input  logic               client_hold_i,
    input  logic               mem_hold_i,
    input  logic               mem_pending_i,
    input  logic               alu_busy_i,
    input  logic               bus_wait_i,
    input  logic               halt_i,
    input  flow_pkg::branch_t  branch_i,
    input  flow_pkg::jump_t    jump_i,
    input  flow_pkg::word_t    imm_i,
    input  flow_pkg::word_t    rs1_i,
    input  flow_pkg::word_t    ex_pc_i,      // base for branch and jal
    input  logic               zero_i,
    input  logic               less_i,
    input  logic               more_eq_i,
    flow_if.ctrl               flow,
    output flow_pkg::word_t    next_pc_o,
    output logic               next_pc_four_o
);

    logic            br_taken;
    flow_pkg::word_t rel_target;   // ex_pc + imm

    assign rel_target = ex_pc_i + imm_i;

    // --------------------
    // branch condition
    always_comb begin
        case (branch_i)
            flow_pkg::BR_BEQ:  br_taken = zero_i;
            flow_pkg::BR_BNE:  br_taken = ~zero_i;
            flow_pkg::BR_BLT,
            flow_pkg::BR_BLTU: br_taken = less_i;
            flow_pkg::BR_BGE,
            flow_pkg::BR_BGEU: br_taken = more_eq_i;
            default:           br_taken = 1'b0;
        endcase
    end

    // --------------------
    // priority decision
    always_comb begin
        // sequential fetch unless redirected below
        next_pc_o      = '0;
        next_pc_four_o = 1'b1;
        flow.pc        = flow_pkg::FLOW_WORK;
        flow.de        = flow_pkg::FLOW_WORK;
        flow.ex        = flow_pkg::FLOW_WORK;
        flow.as        = flow_pkg::FLOW_WORK;
        flow.wb        = flow_pkg::FLOW_WORK;

        if (int_assert_i) begin
            // flush everything, fetch from the handler
            next_pc_o      = int_addr_i;
            next_pc_four_o = 1'b0;
            flow.de        = flow_pkg::FLOW_REFRESH;
            flow.ex        = flow_pkg::FLOW_REFRESH;
            flow.as        = flow_pkg::FLOW_REFRESH;
            flow.wb        = flow_pkg::FLOW_REFRESH;
        end else if (client_hold_i) begin
            flow.pc = flow_pkg::FLOW_STOP;
            flow.de = flow_pkg::FLOW_STOP;
            flow.ex = flow_pkg::FLOW_STOP;
            flow.as = flow_pkg::FLOW_STOP;
            flow.wb = flow_pkg::FLOW_STOP;
        end else if (mem_hold_i) begin
            flow.pc = flow_pkg::FLOW_STOP;
            flow.de = flow_pkg::FLOW_STOP;
            flow.ex = flow_pkg::FLOW_STOP;
            flow.as = flow_pkg::FLOW_STOP;
            flow.wb = flow_pkg::FLOW_REFRESH;   // bubble behind the access
        end else if (mem_pending_i) begin
            flow.pc = flow_pkg::FLOW_STOP;
            flow.de = flow_pkg::FLOW_STOP;
            flow.ex = flow_pkg::FLOW_REFRESH;
        end else if (alu_busy_i) begin
            flow.pc = flow_pkg::FLOW_STOP;
            flow.de = flow_pkg::FLOW_STOP;
            flow.ex = flow_pkg::FLOW_STOP;      // divider keeps its op
            flow.as = flow_pkg::FLOW_REFRESH;
        end else if (bus_wait_i) begin
            flow.pc = flow_pkg::FLOW_STOP;
            flow.de = flow_pkg::FLOW_REFRESH;   // no instruction fetched
        end else if (branch_i != flow_pkg::BR_NONE) begin
            if (br_taken) begin
                next_pc_o      = rel_target;
                next_pc_four_o = 1'b0;
                flow.de        = flow_pkg::FLOW_REFRESH;
                flow.ex        = flow_pkg::FLOW_REFRESH;
            end
        end else if (jump_i != flow_pkg::JMP_NONE) begin
            next_pc_four_o = 1'b0;
            flow.de        = flow_pkg::FLOW_REFRESH;
            flow.ex        = flow_pkg::FLOW_REFRESH;
            case (jump_i)
                flow_pkg::JMP_JAL:   next_pc_o = rel_target;
                flow_pkg::JMP_JALR:  next_pc_o = rs1_i + imm_i;
                default:             next_pc_o = ex_pc_i + flow_pkg::PC_STEP;   // fence
            endcase
        end else if (halt_i) begin
            flow.pc = flow_pkg::FLOW_STOP;
            flow.de = flow_pkg::FLOW_STOP;
            flow.ex = flow_pkg::FLOW_STOP;
            flow.as = flow_pkg::FLOW_STOP;
            flow.wb = flow_pkg::FLOW_STOP;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# compile and run the pipeline control testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary -f flist.f --top-module tb_pipe_ctrl -o tb_pipe_ctrl \
    && ./obj_dir/tb_pipe_ctrl \
    || exit 1

/* sim/tb_pipe_ctrl.sv */
// pipeline control testbench
// directed tests against a cycle model of the pc register and stage tags

`timescale 1ns/1ns

module tb_pipe_ctrl;

    logic              clk;
    logic              rst_i;
    logic              int_assert_i;
    flow_pkg::word_t   int_addr_i;
    logic              client_hold_i;
    logic              mem_hold_i;
    logic              mem_pending_i;
    logic              alu_busy_i;
    logic              bus_wait_i;
    logic              halt_i;
    flow_pkg::branch_t branch_i;
    flow_pkg::jump_t   jump_i;
    flow_pkg::word_t   imm_i;
    flow_pkg::word_t   rs1_i;
    flow_pkg::word_t   rs2_i;
    flow_pkg::word_t   pc_o;
    flow_pkg::word_t   de_pc_o;
    flow_pkg::word_t   ex_pc_o;
    flow_pkg::word_t   as_pc_o;
    flow_pkg::word_t   wb_pc_o;
    logic              de_valid_o;
    logic              ex_valid_o;
    logic              as_valid_o;
    logic              wb_valid_o;

    integer seed;

    // model state, tag index 0..3 is de ex as wb
    flow_pkg::word_t m_pc;
    flow_pkg::word_t m_tag_pc [4];
    logic            m_tag_v  [4];
    flow_pkg::flow_t m_cmd    [5];   // pc de ex as wb

    pipe_ctrl_top pipe_ctrl_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // watchdog for the whole run
    initial begin
        #(40 * 5000);
        $display("timeout: the test sequence did not finish in time");
        $display("Simulation failed");
        $fatal(1);
    end

    // --------------------
    // checking
    task automatic check_val(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error: %s %s expected %h actual %h", test, what, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic compare_all(input string test);
        check_val(test, "pc", m_pc, pc_o);
        check_val(test, "de_pc", m_tag_pc[0], de_pc_o);
        check_val(test, "ex_pc", m_tag_pc[1], ex_pc_o);
        check_val(test, "as_pc", m_tag_pc[2], as_pc_o);
        check_val(test, "wb_pc", m_tag_pc[3], wb_pc_o);
        check_val(test, "de_valid", 32'(m_tag_v[0]), 32'(de_valid_o));
        check_val(test, "ex_valid", 32'(m_tag_v[1]), 32'(ex_valid_o));
        check_val(test, "as_valid", 32'(m_tag_v[2]), 32'(as_valid_o));
        check_val(test, "wb_valid", 32'(m_tag_v[3]), 32'(wb_valid_o));
    endtask

    // --------------------
    // reference model
    function automatic logic branch_taken(input flow_pkg::branch_t br,
                                          input flow_pkg::word_t a, input flow_pkg::word_t b);
        case (br)
            flow_pkg::BR_BEQ:  return a == b;
            flow_pkg::BR_BNE:  return a != b;
            flow_pkg::BR_BLT:  return $signed(a) < $signed(b);
            flow_pkg::BR_BGE:  return $signed(a) >= $signed(b);
            flow_pkg::BR_BLTU: return a < b;
            flow_pkg::BR_BGEU: return a >= b;
            default:           return 1'b0;
        endcase
    endfunction

    task automatic set_cmds(input flow_pkg::flow_t p, input flow_pkg::flow_t d,
                            input flow_pkg::flow_t e, input flow_pkg::flow_t a,
                            input flow_pkg::flow_t w);
        m_cmd[0] = p;
        m_cmd[1] = d;
        m_cmd[2] = e;
        m_cmd[3] = a;
        m_cmd[4] = w;
    endtask

    task automatic model_reset();
        m_pc = flow_pkg::RESET_PC;
        for (int i = 0; i < 4; i++) begin
            m_tag_pc[i] = '0;
            m_tag_v[i]  = 1'b0;
        end
    endtask

    // one clock of the model, from the inputs currently driven
    task automatic model_step();
        flow_pkg::word_t np;
        logic            seq;
        flow_pkg::word_t old_pc [4];
        logic            old_v  [4];
        np  = '0;
        seq = 1'b1;
        set_cmds(flow_pkg::FLOW_WORK, flow_pkg::FLOW_WORK, flow_pkg::FLOW_WORK,
                 flow_pkg::FLOW_WORK, flow_pkg::FLOW_WORK);
        if (int_assert_i) begin
            set_cmds(flow_pkg::FLOW_WORK, flow_pkg::FLOW_REFRESH, flow_pkg::FLOW_REFRESH,
                     flow_pkg::FLOW_REFRESH, flow_pkg::FLOW_REFRESH);
            np  = int_addr_i;
            seq = 1'b0;
        end else if (client_hold_i) begin
            set_cmds(flow_pkg::FLOW_STOP, flow_pkg::FLOW_STOP, flow_pkg::FLOW_STOP,
                     flow_pkg::FLOW_STOP, flow_pkg::FLOW_STOP);
        end else if (mem_hold_i) begin
            set_cmds(flow_pkg::FLOW_STOP, flow_pkg::FLOW_STOP, flow_pkg::FLOW_STOP,
                     flow_pkg::FLOW_STOP, flow_pkg::FLOW_REFRESH);
        end else if (mem_pending_i) begin
            set_cmds(flow_pkg::FLOW_STOP, flow_pkg::FLOW_STOP, flow_pkg::FLOW_REFRESH,
                     flow_pkg::FLOW_WORK, flow_pkg::FLOW_WORK);
        end else if (alu_busy_i) begin
            set_cmds(flow_pkg::FLOW_STOP, flow_pkg::FLOW_STOP, flow_pkg::FLOW_STOP,
                     flow_pkg::FLOW_REFRESH, flow_pkg::FLOW_WORK);
        end else if (bus_wait_i) begin
            set_cmds(flow_pkg::FLOW_STOP, flow_pkg::FLOW_REFRESH, flow_pkg::FLOW_WORK,
                     flow_pkg::FLOW_WORK, flow_pkg::FLOW_WORK);
        end else if (branch_i != flow_pkg::BR_NONE) begin
            if (branch_taken(branch_i, rs1_i, rs2_i)) begin
                m_cmd[1] = flow_pkg::FLOW_REFRESH;
                m_cmd[2] = flow_pkg::FLOW_REFRESH;
                np       = m_tag_pc[1] + imm_i;
                seq      = 1'b0;
            end
        end else if (jump_i != flow_pkg::JMP_NONE) begin
            m_cmd[1] = flow_pkg::FLOW_REFRESH;
            m_cmd[2] = flow_pkg::FLOW_REFRESH;
            seq      = 1'b0;
            if (jump_i == flow_pkg::JMP_JAL)
                np = m_tag_pc[1] + imm_i;
            else if (jump_i == flow_pkg::JMP_JALR)
                np = rs1_i + imm_i;
            else
                np = m_tag_pc[1] + flow_pkg::PC_STEP;   // fence refetch
        end else if (halt_i) begin
            set_cmds(flow_pkg::FLOW_STOP, flow_pkg::FLOW_STOP, flow_pkg::FLOW_STOP,
                     flow_pkg::FLOW_STOP, flow_pkg::FLOW_STOP);
        end

        for (int i = 0; i < 4; i++) begin
            old_pc[i] = m_tag_pc[i];
            old_v[i]  = m_tag_v[i];
        end
        // de takes the old fetch address
        for (int i = 0; i < 4; i++) begin
            if (m_cmd[i+1] == flow_pkg::FLOW_WORK) begin
                m_tag_pc[i] = (i == 0) ? m_pc : old_pc[i-1];
                m_tag_v[i]  = (i == 0) ? 1'b1 : old_v[i-1];
            end else if (m_cmd[i+1] == flow_pkg::FLOW_REFRESH) begin
                m_tag_pc[i] = '0;
                m_tag_v[i]  = 1'b0;
            end
        end
        if (m_cmd[0] == flow_pkg::FLOW_WORK)
            m_pc = seq ? m_pc + flow_pkg::PC_STEP : np;
    endtask

    // --------------------
    // stimulus helpers
    task automatic drive_idle();
        int_assert_i  = 1'b0;
        int_addr_i    = '0;
        client_hold_i = 1'b0;
        mem_hold_i    = 1'b0;
        mem_pending_i = 1'b0;
        alu_busy_i    = 1'b0;
        bus_wait_i    = 1'b0;
        halt_i        = 1'b0;
        branch_i      = flow_pkg::BR_NONE;
        jump_i        = flow_pkg::JMP_NONE;
        imm_i         = '0;
        rs1_i         = '0;
        rs2_i         = '0;
    endtask

    task automatic set_stall(input int idx, input logic val);
        case (idx)
            0:       client_hold_i = val;
            1:       mem_hold_i    = val;
            2:       mem_pending_i = val;
            3:       alu_busy_i    = val;
            4:       bus_wait_i    = val;
            default: halt_i        = val;
        endcase
    endtask

    // inputs are set at the falling edge, outputs checked at the next one
    task automatic step_cycle(input string test);
        model_step();
        @(posedge clk);
        @(negedge clk);
        compare_all(test);
    endtask

    // --------------------
    // tests
    task automatic reset_fill();
        int waited;
        drive_idle();
        rst_i = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        model_reset();
        compare_all("reset_fill");
        waited = 0;
        while (!wb_valid_o) begin
            if (waited == 10) begin
                $display("timeout: wb stage never became valid after reset");
                $display("Simulation failed");
                $fatal(1);
            end
            step_cycle("reset_fill");
            waited++;
        end
        check_val("reset_fill", "de_pc", m_pc - 32'd4, de_pc_o);
        check_val("reset_fill", "ex_pc", m_pc - 32'd8, ex_pc_o);
        check_val("reset_fill", "as_pc", m_pc - 32'd12, as_pc_o);
        check_val("reset_fill", "wb_pc", m_pc - 32'd16, wb_pc_o);
    endtask

    task automatic branches();
        flow_pkg::word_t a;
        flow_pkg::word_t b;
        flow_pkg::word_t exp_pc;
        logic            tk;
        for (int k = 1; k <= 6; k++) begin
            for (int n = 0; n < 3; n++) begin
                a = $random(seed);
                if (n == 0)
                    b = a;
                else if (n == 1)
                    b = $random(seed) | 32'd1;
                else
                    b = a ^ 32'h8000_0000;   // opposite sign
                if (n == 1 && b == a)
                    b = ~a;
                branch_i = flow_pkg::branch_t'(k);
                rs1_i    = a;
                rs2_i    = b;
                imm_i    = $random(seed) & 32'h0000_0ffc;
                tk       = branch_taken(branch_i, a, b);
                exp_pc   = tk ? m_tag_pc[1] + imm_i : m_pc + 32'd4;
                step_cycle("branches");
                check_val("branches", "target", exp_pc, pc_o);
                if (tk) begin
                    check_val("branches", "de flushed", 32'd0, 32'(de_valid_o));
                    check_val("branches", "ex flushed", 32'd0, 32'(ex_valid_o));
                end
                drive_idle();
                repeat (2) step_cycle("branches");
            end
        end
    endtask

    task automatic jumps();
        flow_pkg::word_t exp_pc;
        flow_pkg::word_t old_ex;
        for (int k = 1; k <= 3; k++) begin
            jump_i = flow_pkg::jump_t'(k);
            rs1_i  = $random(seed) & 32'hffff_fffc;
            imm_i  = $random(seed) & 32'h0000_0ffc;
            old_ex = m_tag_pc[1];
            if (k == 1)
                exp_pc = old_ex + imm_i;
            else if (k == 2)
                exp_pc = rs1_i + imm_i;
            else
                exp_pc = old_ex + 32'd4;
            step_cycle("jumps");
            check_val("jumps", "target", exp_pc, pc_o);
            check_val("jumps", "de flushed", 32'd0, 32'(de_valid_o));
            check_val("jumps", "ex flushed", 32'd0, 32'(ex_valid_o));
            check_val("jumps", "as advanced", old_ex, as_pc_o);
            drive_idle();
            repeat (3) step_cycle("jumps");
        end
    endtask

    task automatic stalls();
        flow_pkg::word_t held_pc;
        for (int idx = 0; idx < 6; idx++) begin
            drive_idle();
            set_stall(idx, 1'b1);
            held_pc = m_pc;
            repeat (3) step_cycle("stalls");
            check_val("stalls", "pc held", held_pc, pc_o);
            set_stall(idx, 1'b0);
            repeat (4) step_cycle("stalls");   // resume and refill
        end
    endtask

    task automatic interrupt_priority();
        flow_pkg::word_t held_pc;
        for (int idx = 0; idx < 7; idx++) begin
            drive_idle();
            int_assert_i = 1'b1;
            int_addr_i   = $random(seed) & 32'hffff_fffc;
            if (idx < 6) begin
                set_stall(idx, 1'b1);
            end else begin
                branch_i = flow_pkg::BR_BEQ;
                rs1_i    = 32'h1234_5678;
                rs2_i    = 32'h1234_5678;
                imm_i    = 32'h0000_0100;
            end
            step_cycle("priority");
            check_val("priority", "int target", int_addr_i, pc_o);
            check_val("priority", "wb flushed", 32'd0, 32'(wb_valid_o));
            drive_idle();
            repeat (4) step_cycle("priority");
        end
        // a held stall beats a taken branch, halt ranks below branches
        for (int idx = 0; idx < 5; idx++) begin
            drive_idle();
            set_stall(idx, 1'b1);
            branch_i = flow_pkg::BR_BEQ;
            rs1_i    = $random(seed);
            rs2_i    = rs1_i;
            imm_i    = $random(seed) & 32'h0000_0ffc;
            held_pc  = m_pc;
            step_cycle("priority");
            check_val("priority", "stall over branch", held_pc, pc_o);
            drive_idle();
            repeat (4) step_cycle("priority");
        end
    endtask

    initial begin
        seed = 32'h5104_c4aa;
        rst_i = 1'b1;
        drive_idle();
        reset_fill();
        branches();
        jumps();
        stalls();
        interrupt_priority();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* src/pc_reg.sv */
// program counter
// fetch address register, steps by one word or loads a redirect target

`timescale 1ns/1ns

module pc_reg (
    input  logic            clk,
    input  logic            rst_i,
    flow_if.pc_side         flow,
    input  flow_pkg::word_t next_pc_i,
    input  logic            next_pc_four_i,
    output flow_pkg::word_t pc_o
);

    flow_pkg::word_t pc_q;
    flow_pkg::word_t pc_d;

    // sequential step or redirect
    assign pc_d = next_pc_four_i ? pc_q + flow_pkg::PC_STEP : next_pc_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= flow_pkg::RESET_PC;
        end else if (flow.pc == flow_pkg::FLOW_WORK) begin
            pc_q <= pc_d;
        end
        // stop and refresh both hold the address
    end

    assign pc_o = pc_q;

endmodule

/* src/pipe_ctrl_top.sv */
// pipeline control top
// flow controller, branch compare, pc register and stage tags

`timescale 1ns/1ns

module pipe_ctrl_top (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              int_assert_i,
    input  flow_pkg::word_t   int_addr_i,
    input  logic              client_hold_i,
    input  logic              mem_hold_i,
    input  logic              mem_pending_i,
    input  logic              alu_busy_i,
    input  logic              bus_wait_i,
    input  logic              halt_i,
    input  flow_pkg::branch_t branch_i,
    input  flow_pkg::jump_t   jump_i,
    input  flow_pkg::word_t   imm_i,
    input  flow_pkg::word_t   rs1_i,
    input  flow_pkg::word_t   rs2_i,
    output flow_pkg::word_t   pc_o,
    output flow_pkg::word_t   de_pc_o,
    output flow_pkg::word_t   ex_pc_o,
    output flow_pkg::word_t   as_pc_o,
    output flow_pkg::word_t   wb_pc_o,
    output logic              de_valid_o,
    output logic              ex_valid_o,
    output logic              as_valid_o,
    output logic              wb_valid_o
);

    logic            zero;
    logic            less;
    logic            more_eq;
    flow_pkg::word_t next_pc;
    logic            next_pc_four;

    flow_if flow_bus ();

    // --------------------
    // decision logic
    branch_cmp branch_cmp_inst (
        .branch_i  (branch_i),
        .rs1_i     (rs1_i),
        .rs2_i     (rs2_i),
        .zero_o    (zero),
        .less_o    (less),
        .more_eq_o (more_eq)
    );

    flow_ctrl flow_ctrl_inst (
        .int_assert_i   (int_assert_i),
        .int_addr_i     (int_addr_i),
        .client_hold_i  (client_hold_i),
        .mem_hold_i     (mem_hold_i),
        .mem_pending_i  (mem_pending_i),
        .alu_busy_i     (alu_busy_i),
        .bus_wait_i     (bus_wait_i),
        .halt_i         (halt_i),
        .branch_i       (branch_i),
        .jump_i         (jump_i),
        .imm_i          (imm_i),
        .rs1_i          (rs1_i),
        .ex_pc_i        (ex_pc_o),        // target base is the ex tag
        .zero_i         (zero),
        .less_i         (less),
        .more_eq_i      (more_eq),
        .flow           (flow_bus.ctrl),
        .next_pc_o      (next_pc),
        .next_pc_four_o (next_pc_four)
    );

    // --------------------
    // state
    pc_reg pc_reg_inst (
        .clk            (clk),
        .rst_i          (rst_i),
        .flow           (flow_bus.pc_side),
        .next_pc_i      (next_pc),
        .next_pc_four_i (next_pc_four),
        .pc_o           (pc_o)
    );

    stage_chain stage_chain_inst (
        .clk        (clk),
        .rst_i      (rst_i),
        .flow       (flow_bus.pipe),
        .fetch_pc_i (pc_o),
        .de_pc_o    (de_pc_o),
        .ex_pc_o    (ex_pc_o),
        .as_pc_o    (as_pc_o),
        .wb_pc_o    (wb_pc_o),
        .de_valid_o (de_valid_o),
        .ex_valid_o (ex_valid_o),
        .as_valid_o (as_valid_o),
        .wb_valid_o (wb_valid_o)
    );

endmodule

/* src/stage_chain.sv */
// stage tag chain
// pc and valid tags for de, ex, as and wb, each under its own flow command

`timescale 1ns/1ns

module stage_chain (
    input  logic            clk,
    input  logic            rst_i,
    flow_if.pipe            flow,
    input  flow_pkg::word_t fetch_pc_i,
    output flow_pkg::word_t de_pc_o,
    output flow_pkg::word_t ex_pc_o,
    output flow_pkg::word_t as_pc_o,
    output flow_pkg::word_t wb_pc_o,
    output logic            de_valid_o,
    output logic            ex_valid_o,
    output logic            as_valid_o,
    output logic            wb_valid_o
);

    localparam int N_STAGE = 4;   // de ex as wb

    flow_pkg::flow_t cmd       [N_STAGE];
    flow_pkg::word_t tag_pc    [N_STAGE];
    logic            tag_valid [N_STAGE];

    assign cmd[0] = flow.de;
    assign cmd[1] = flow.ex;
    assign cmd[2] = flow.as;
    assign cmd[3] = flow.wb;

    // --------------------
    // tag registers
    always_ff @(posedge clk) begin
        for (int i = 0; i < N_STAGE; i++) begin
            if (rst_i) begin
                tag_pc[i]    <= '0;
                tag_valid[i] <= 1'b0;
            end else begin
                case (cmd[i])
                    flow_pkg::FLOW_WORK: begin
                        if (i == 0) begin
                            tag_pc[i]    <= fetch_pc_i;   // new fetch enters de
                            tag_valid[i] <= 1'b1;
                        end else begin
                            tag_pc[i]    <= tag_pc[i-1];
                            tag_valid[i] <= tag_valid[i-1];
                        end
                    end
                    flow_pkg::FLOW_REFRESH: begin
                        tag_pc[i]    <= '0;   // bubble
                        tag_valid[i] <= 1'b0;
                    end
                    default: ;   // stop holds
                endcase
            end
        end
    end

    assign de_pc_o    = tag_pc[0];
    assign ex_pc_o    = tag_pc[1];
    assign as_pc_o    = tag_pc[2];
    assign wb_pc_o    = tag_pc[3];
    assign de_valid_o = tag_valid[0];
    assign ex_valid_o = tag_valid[1];
    assign as_valid_o = tag_valid[2];
    assign wb_valid_o = tag_valid[3];

endmodule
